/* rtl/sound_pkg.sv */
/*
 * Shared types and sizes for the sound timing block.
 * Holds the channel count, field widths, the configuration opcodes
 * and the packed words passed from the host and between stages.
 * Modules that use any of it take it by wildcard import.
 */
package sound_pkg;

    ////////////////////
    // Sizes
    ////////////////////
    localparam int NUM_CH   = 4;                // Tone channels
    localparam int CH_W     = $clog2(NUM_CH);   // Channel select width
    localparam int PERIOD_W = 10;               // Half-period in tone enables, minus one
    localparam int VOL_W    = 4;                // Per channel volume
    localparam int SAMPLE_W = 6;                // 4 x 15 = 60 fits

    // Host configuration opcodes
    typedef enum logic [1:0] {
        OP_NOP     = 2'd0,
        OP_PERIOD  = 2'd1,   // Load period, applied at next wrap
        OP_VOLUME  = 2'd2,   // Low VOL_W bits of data
        OP_RESTART = 2'd3    // Counter to zero, level high
    } cfg_op_e;

    ////////////////////
    // Packed words
    ////////////////////
    // Host write, 14 bits
    typedef struct packed {
        cfg_op_e             op;
        logic [CH_W-1:0]     chan;
        logic [PERIOD_W-1:0] data;
    } cfg_word_t;

    // Tone bank to mixer, 20 bits
    typedef struct packed {
        logic [NUM_CH-1:0]            level;  // Square outputs
        logic [NUM_CH-1:0][VOL_W-1:0] vol;    // Current volumes
    } tone_bus_t;

endpackage

/* rtl/cen_frac.sv */
/*
 * Fractional-step clock enable from the 48 MHz system clock.
 * A phase accumulator adds STEP each cycle and wraps at LIM, giving
 * exactly STEP enables in any LIM cycles (105/1408 -> 3.579545 MHz).
 * tone_cen_half pulses on every second tone_cen.
 * An accumulator found out of range is cleared.
 */
`timescale 1ns/10ps

module cen_frac #(
    parameter int STEP = 105,   // Phase increment per clock
    parameter int LIM  = 1408   // Phase wrap point
) (
    input  logic clk,
    input  logic reset,
    output logic tone_cen,
    output logic tone_cen_half
);

    // Wide enough for acc + STEP while acc is just under LIM + STEP
    localparam int ACC_W = $clog2(LIM + 2 * STEP + 1);

    localparam logic [ACC_W-1:0] STEP_V = ACC_W'(STEP);
    localparam logic [ACC_W-1:0] LIM_V  = ACC_W'(LIM);
    localparam logic [ACC_W-1:0] ABSMAX = ACC_W'(LIM + STEP); // Never legal

    logic [ACC_W-1:0] acc;        // Phase
    logic [ACC_W-1:0] next_sum;   // Phase plus step
    logic [ACC_W-1:0] next_wrap;  // Same, minus one full turn
    logic             alt;        // Selects every second enable

    ////////////////////
    // Next phase
    ////////////////////
    always_comb begin
        next_sum  = acc + STEP_V;
        next_wrap = next_sum - LIM_V;
    end

    ////////////////////
    // Accumulator and enables
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            acc           <= '0;
            alt           <= 1'b0;
            tone_cen      <= 1'b0;
            tone_cen_half <= 1'b0;
        end else begin
            tone_cen      <= 1'b0;   // Single cycle strobes
            tone_cen_half <= 1'b0;
            if (acc >= ABSMAX) begin
                // Upset phase, start over
                acc <= '0;
                alt <= 1'b0;
            end else if (next_sum >= LIM_V) begin
                acc           <= next_wrap;   // Keep the remainder
                tone_cen      <= 1'b1;
                alt           <= ~alt;
                tone_cen_half <= alt;         // Second of each pair
            end else begin
                acc <= next_sum;
            end
        end
    end

endmodule

/* rtl/cen_div.sv */
/*
 * Integer divider clock enable.
 * sample_cen pulses once every DIV clocks (125 -> 384 kHz at 48 MHz).
 * sample_cen_b is the 180 degree twin, DIV/2 clocks after each sample_cen.
 * Both come from registered compares on one wrap-around counter.
 */
`timescale 1ns/10ps

module cen_div #(
    parameter int DIV = 125   // Clocks per enable, at least 2
) (
    input  logic clk,
    input  logic reset,
    output logic sample_cen,
    output logic sample_cen_b
);

    localparam int CNT_W = $clog2(DIV + 1);

    localparam logic [CNT_W-1:0] LAST   = CNT_W'(DIV - 1);  // Wrap value
    localparam logic [CNT_W-1:0] HALF_AT = CNT_W'(DIV / 2); // Twin phase

    logic [CNT_W-1:0] cnt;

    // Free running, 0 .. DIV-1
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (cnt == LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    ////////////////////
    // Registered compares
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_cen   <= 1'b0;
            sample_cen_b <= 1'b0;
        end else begin
            sample_cen   <= cnt == '0;       // Main phase
            sample_cen_b <= cnt == HALF_AT;  // Half a period later
        end
    end

endmodule

/* rtl/tone_bank.sv */
/*
 * Square-wave tone channels.
 * Host writes set per channel period and volume, or restart a channel.
 * Each channel counts tone enables and toggles its level every period+1
 * enables; a period of 0 keeps the level high.
 * New periods are picked up when the running half-period ends.
 */
`timescale 1ns/10ps

module tone_bank import sound_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      tone_cen,
    input  logic      cfg_we,
    input  cfg_word_t cfg,
    output tone_bus_t tone
);

    logic [PERIOD_W-1:0]          period  [NUM_CH];  // Host written
    logic [PERIOD_W-1:0]          act_per [NUM_CH];  // In use by counter
    logic [PERIOD_W-1:0]          cnt     [NUM_CH];  // Half-period counter
    logic [NUM_CH-1:0][VOL_W-1:0] vol;
    logic [NUM_CH-1:0]            level;

    // Per channel write decode
    logic [NUM_CH-1:0] wr_period;
    logic [NUM_CH-1:0] wr_volume;
    logic [NUM_CH-1:0] wr_restart;

    ////////////////////
    // Config decode
    ////////////////////
    always_comb begin
        wr_period  = '0;
        wr_volume  = '0;
        wr_restart = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (cfg_we && cfg.chan == CH_W'(ch)) begin
                case (cfg.op)
                    OP_PERIOD:  wr_period[ch]  = 1'b1;
                    OP_VOLUME:  wr_volume[ch]  = 1'b1;
                    OP_RESTART: wr_restart[ch] = 1'b1;
                    default: ;                    // OP_NOP
                endcase
            end
        end
    end

    ////////////////////
    // Host registers
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                period[ch] <= '0;
            end
            vol <= '0;
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (wr_period[ch]) period[ch] <= cfg.data;
                if (wr_volume[ch]) vol[ch]    <= cfg.data[VOL_W-1:0];
            end
        end
    end

    ////////////////////
    // Channel counters
    ////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                act_per[ch] <= '0;
                cnt[ch]     <= '0;
            end
            level <= '1;   // All channels start high
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (wr_restart[ch]) begin
                    // Restart wins over a same cycle enable
                    cnt[ch]     <= '0;
                    act_per[ch] <= period[ch];
                    level[ch]   <= 1'b1;
                end else if (tone_cen) begin
                    if (cnt[ch] == act_per[ch]) begin
                        cnt[ch]     <= '0;
                        act_per[ch] <= period[ch];   // Pending period lands here
                        // Period 0 parks the channel high
                        if (act_per[ch] == '0 || period[ch] == '0) begin
                            level[ch] <= 1'b1;
                        end else begin
                            level[ch] <= ~level[ch];
                        end
                    end else begin
                        cnt[ch] <= cnt[ch] + 1'b1;
                    end
                end
            end
        end
    end

    // To the mixer
    assign tone.level = level;
    assign tone.vol   = vol;

endmodule

/* rtl/tone_mixer.sv */
/*
 * Channel mixer.
 * Adds the volumes of the channels whose square output is high and
 * registers the sum on each sample enable.
 * sample_valid marks the cycle in which sample takes the new value,
 * one clock after sample_cen.
 */
`timescale 1ns/10ps

module tone_mixer import sound_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                sample_cen,
    input  tone_bus_t           tone,
    output logic [SAMPLE_W-1:0] sample,
    output logic                sample_valid
);

    logic [NUM_CH-1:0][VOL_W-1:0] gated;    // Volume or zero
    logic [SAMPLE_W-1:0]          mix_sum;  // Sum of gated volumes

    ////////////////////
    // Gate and add
    ////////////////////
    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            gated[ch] = tone.level[ch] ? tone.vol[ch] : '0;  // Low channel is silent
        end
    end

    always_comb begin
        mix_sum = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            mix_sum = mix_sum + SAMPLE_W'(gated[ch]);  // No overflow, 60 max
        end
    end

    ////////////////////
    // Sample register
    ////////////////////
    always_ff @(posedge clk) begin
        if (sample_cen) begin
            sample <= mix_sum;
        end
    end

    // Valid lines up with the sample update
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= sample_cen;
        end
    end

endmodule

/* rtl/sound_timing_top.sv */
/*
 * Sound timing block, top level.
 * Chains the tone enable generator, the sample rate divider, the tone
 * bank and the mixer. All rates are clock enables on the 48 MHz clock.
 * Host writes come in as single cycle cfg_we strobes.
 */
`timescale 1ns/10ps

module sound_timing_top import sound_pkg::*; #(
    parameter int STEP = 105,    // Tone enable phase step
    parameter int LIM  = 1408,   // Tone enable phase wrap
    parameter int DIV  = 125     // Clocks per sample
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                cfg_we,
    input  cfg_word_t           cfg,
    output logic                tone_cen,
    output logic                tone_cen_half,
    output logic                sample_cen,
    output logic                sample_cen_b,
    output logic [NUM_CH-1:0]   levels,
    output logic [SAMPLE_W-1:0] sample,
    output logic                sample_valid
);

    tone_bus_t tone;   // Bank to mixer

    ////////////////////
    // Enables
    ////////////////////
    cen_frac #(.STEP(STEP), .LIM(LIM)) u_cen_frac (
        .clk          (clk),
        .reset        (reset),
        .tone_cen     (tone_cen),
        .tone_cen_half(tone_cen_half)
    );

    cen_div #(.DIV(DIV)) u_cen_div (
        .clk         (clk),
        .reset       (reset),
        .sample_cen  (sample_cen),
        .sample_cen_b(sample_cen_b)
    );

    ////////////////////
    // Tones and mix
    ////////////////////
    tone_bank u_tone_bank (
        .clk     (clk),
        .reset   (reset),
        .tone_cen(tone_cen),
        .cfg_we  (cfg_we),
        .cfg     (cfg),
        .tone    (tone)
    );

    tone_mixer u_tone_mixer (
        .clk         (clk),
        .reset       (reset),
        .sample_cen  (sample_cen),
        .tone        (tone),
        .sample      (sample),
        .sample_valid(sample_valid)
    );

    assign levels = tone.level;   // Square outputs for observation

endmodule

/* test/tb_vectors.svh */
/*
 * Stimulus table for the sound timing testbench, included in its module.
 * Columns: name (12 characters), period and volume per channel (ch3..ch0),
 * window in clocks, expected sample with every channel high, and
 * expected level toggles per channel (ch3..ch0).
 * Toggles come from 105 tone enables per 1408 clocks, so 210 per 2816,
 * divided by period+1.
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
    logic [8*12-1:0]                 name;
    logic [NUM_CH-1:0][PERIOD_W-1:0] period;       // ch3..ch0
    logic [NUM_CH-1:0][VOL_W-1:0]    vol;          // ch3..ch0
    logic [15:0]                     window;       // Clocks observed
    logic [SAMPLE_W-1:0]             exp_sample;   // Sum of all volumes
    logic [NUM_CH-1:0][7:0]          exp_toggles;  // 210 / (period+1)
} vec_t;

localparam int NUM_VEC = 6;

localparam vec_t VECTORS [NUM_VEC] = '{
    // Periods all 0, channels parked high
    '{name: "static_zeros", period: '{10'd0, 10'd0, 10'd0, 10'd0},
      vol: '{4'd0, 4'd0, 4'd0, 4'd0}, window: 16'd750, exp_sample: 6'd0,
      exp_toggles: '{8'd0, 8'd0, 8'd0, 8'd0}},
    '{name: "static_max15", period: '{10'd0, 10'd0, 10'd0, 10'd0},
      vol: '{4'd15, 4'd15, 4'd15, 4'd15}, window: 16'd750, exp_sample: 6'd60,
      exp_toggles: '{8'd0, 8'd0, 8'd0, 8'd0}},
    '{name: "static_mixed", period: '{10'd0, 10'd0, 10'd0, 10'd0},
      vol: '{4'd3, 4'd7, 4'd1, 4'd9}, window: 16'd750, exp_sample: 6'd20,
      exp_toggles: '{8'd0, 8'd0, 8'd0, 8'd0}},
    // Running tones, windows of two full phase turns
    '{name: "tone_spread4", period: '{10'd20, 10'd14, 10'd9, 10'd6},
      vol: '{4'd8, 4'd4, 4'd2, 4'd1}, window: 16'd2816, exp_sample: 6'd15,
      exp_toggles: '{8'd10, 8'd14, 8'd21, 8'd30}},
    '{name: "tone_partial", period: '{10'd0, 10'd34, 10'd0, 10'd2},
      vol: '{4'd5, 4'd6, 4'd7, 4'd12}, window: 16'd2816, exp_sample: 6'd30,
      exp_toggles: '{8'd0, 8'd6, 8'd0, 8'd70}},
    '{name: "tone_fastmix", period: '{10'd1, 10'd4, 10'd0, 10'd13},
      vol: '{4'd15, 4'd15, 4'd15, 4'd15}, window: 16'd2816, exp_sample: 6'd60,
      exp_toggles: '{8'd105, 8'd42, 8'd0, 8'd15}}
};

`endif

/* test/tb_sound_timing.sv */
/*
 * Testbench for the sound timing block.
 * Checks reset state, tone and sample enable rates, then runs the
 * stimulus table (mix values and tone toggle counts) and two host
 * reconfiguration cases. Inputs change on the falling clock edge.
 */
`timescale 1ns/10ps

module tb_sound_timing import sound_pkg::*;;

    localparam int STEP = 105;
    localparam int LIM  = 1408;
    localparam int DIV  = 125;

    `include "tb_vectors.svh"

    logic                clk, reset, cfg_we;
    cfg_word_t           cfg;
    logic                tone_cen, tone_cen_half, sample_cen, sample_cen_b, sample_valid;
    logic [NUM_CH-1:0]   levels;
    logic [SAMPLE_W-1:0] sample;

    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    err_mark;
    string cur_test;
    int    vol_set [NUM_CH];   // Volumes as written by the host
    int    per_set [NUM_CH];   // Periods as written by the host

    sound_timing_top #(.STEP(STEP), .LIM(LIM), .DIV(DIV)) dut (
        .clk(clk), .reset(reset), .cfg_we(cfg_we), .cfg(cfg),
        .tone_cen(tone_cen), .tone_cen_half(tone_cen_half),
        .sample_cen(sample_cen), .sample_cen_b(sample_cen_b),
        .levels(levels), .sample(sample), .sample_valid(sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 100 MHz sim clock
    end

    ////////////////////
    // Bookkeeping
    ////////////////////
    task automatic start_test(input string name);
        cur_test = name;
        err_mark = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("PASS  %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL  %s, %0d errors", cur_test, errors - err_mark);
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual,
                               input int tol);
        int diff;
        diff = (actual > expected) ? actual - expected : expected - actual;
        if (diff > tol) begin
            errors++;
            $display("** Error: %s %s: expected %0d (+/- %0d), actual %0d",
                     cur_test, what, expected, tol, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("Error: %s: %s", cur_test, msg);
    endtask

    // Mix model over the high channels
    function automatic int gated_sum(input logic [NUM_CH-1:0] lv);
        int sum;
        sum = 0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (lv[ch]) sum += vol_set[ch];
        end
        return sum;
    endfunction

    ////////////////////
    // Host writes
    ////////////////////
    task automatic write_cfg(input cfg_op_e op, input int ch, input int data);
        cfg_we    = 1'b1;
        cfg.op    = op;
        cfg.chan  = CH_W'(ch);
        cfg.data  = PERIOD_W'(data);
        if (op == OP_VOLUME) vol_set[ch] = data % 16;
        if (op == OP_PERIOD) per_set[ch] = data;
        @(negedge clk);
        cfg_we = 1'b0;   // One write per clock
    endtask

    task automatic idle_gap();
        repeat (int'($urandom % 32'd16) + 1) @(negedge clk);
    endtask

    // Enough clocks for every test plus slack
    function automatic int run_budget();
        int total;
        total = 8 + 2 * DIV + LIM + 6 * DIV + 2000;
        for (int i = 0; i < NUM_VEC; i++) begin
            total += int'(VECTORS[i].window) + 3 * NUM_CH + 16;
        end
        return total + 5000;
    endfunction

    ////////////////////
    // Tests
    ////////////////////
    task automatic check_reset_state();
        int  cnt;
        start_test("reset_state");
        check_value("strobes", 0, int'({tone_cen, tone_cen_half, sample_cen,
                                         sample_cen_b, sample_valid}), 0);
        check_value("levels", (1 << NUM_CH) - 1, int'(levels), 0);
        reset = 1'b0;
        cnt   = 0;
        while (!sample_cen && cnt < DIV + 5) begin   // No valid ahead of the first enable
            @(negedge clk);
            cnt++;
            if (sample_valid) report_failure("sample_valid before the first sample_cen");
        end
        if (!sample_cen) report_failure("no sample_cen after reset");
        end_test();
    endtask

    task automatic check_tone_enables();
        int n_cen = 0;
        int n_half = 0;
        start_test("tone_enables");
        repeat (LIM) begin
            @(negedge clk);
            n_cen  += int'(tone_cen);
            n_half += int'(tone_cen_half);
        end
        check_value("tone_cen count", STEP, n_cen, 0);
        check_value("2 x tone_cen_half count", STEP, 2 * n_half, 1);   // 52 or 53
        end_test();
    endtask

    task automatic check_sample_enables();
        int last_cen = -1;
        int n_cen = 0;
        start_test("sample_enables");
        for (int cyc = 0; cyc < 5 * DIV + 10; cyc++) begin
            @(negedge clk);
            if (last_cen >= 0) begin
                // Valid one clock and the twin DIV/2 clocks after the last enable
                check_value("sample_valid", int'(cyc - last_cen == 1),
                            int'(sample_valid), 0);
                check_value("sample_cen_b", int'(cyc - last_cen == DIV / 2),
                            int'(sample_cen_b), 0);
            end
            if (sample_cen) begin
                if (last_cen >= 0) check_value("sample_cen spacing", DIV, cyc - last_cen, 0);
                last_cen = cyc;
                n_cen++;
            end
        end
        check_value("sample_cen count", 5, n_cen, 0);
        end_test();
    endtask

    task automatic run_vector(input vec_t v);
        int                tone_cnt = 0;
        int                n_samples = 0;
        int                toggles [NUM_CH];
        int                pend, snap;
        logic [NUM_CH-1:0] prev_lv;
        start_test($sformatf("%s", v.name));
        for (int ch = 0; ch < NUM_CH; ch++) begin
            write_cfg(OP_VOLUME, ch, int'(v.vol[ch]));
            write_cfg(OP_PERIOD, ch, int'(v.period[ch]));
            write_cfg(OP_RESTART, ch, 0);
            toggles[ch] = 0;
        end
        pend    = int'(sample_cen);
        snap    = gated_sum(levels);
        prev_lv = levels;
        for (int c = 0; c < int'(v.window); c++) begin
            @(negedge clk);
            tone_cnt += int'(tone_cen);   // Own count of tone enables
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (levels[ch] != prev_lv[ch]) toggles[ch]++;
            end
            prev_lv = levels;
            check_value("sample_valid", pend, int'(sample_valid), 0);
            if (pend != 0 && sample_valid) begin
                n_samples++;
                check_value("sample", snap, int'(sample), 0);
                // Static mix, or every voiced channel high
                if (per_set.sum() == 0 || gated_sum('1) == snap)
                    check_value("full sample", int'(v.exp_sample), int'(sample), 0);
            end
            pend = int'(sample_cen);
            snap = gated_sum(levels);   // Levels seen by the next sample register
        end
        check_value("sample count", int'(v.window) / DIV, n_samples, 1);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            check_value($sformatf("ch%0d toggles vs table", ch), int'(v.exp_toggles[ch]),
                        toggles[ch], (per_set[ch] == 0) ? 0 : 1);
            if (per_set[ch] != 0)
                check_value($sformatf("ch%0d toggles vs tone_cen", ch),
                            tone_cnt / (per_set[ch] + 1), toggles[ch], 1);
        end
        end_test();
    endtask

    task automatic check_reconfig_volume();
        int cnt = 0;
        start_test("reconfig_vol");
        for (int ch = 0; ch < NUM_CH; ch++) begin
            write_cfg(OP_PERIOD, ch, 0);
            write_cfg(OP_VOLUME, ch, 0);
            write_cfg(OP_RESTART, ch, 0);
        end
        idle_gap();
        write_cfg(OP_VOLUME, 2, 9);
        while (!sample_cen && cnt < DIV + 5) begin
            @(negedge clk);
            cnt++;
        end
        if (!sample_cen) begin
            report_failure("no sample_cen after the volume write");
        end else begin
            @(negedge clk);
            check_value("sample_valid", 1, int'(sample_valid), 0);
            check_value("sample after volume write", gated_sum('1), int'(sample), 0);
        end
        end_test();
    endtask

    task automatic check_reconfig_restart();
        int cnt = 0;
        start_test("reconfig_rst");
        write_cfg(OP_PERIOD, 0, 3);
        write_cfg(OP_RESTART, 0, 0);
        while (levels[0] && cnt < 400) begin   // Wait for a low half-period
            @(negedge clk);
            cnt++;
        end
        if (levels[0]) begin
            report_failure("channel 0 never went low");
        end else begin
            write_cfg(OP_RESTART, 0, 0);
            check_value("level after restart", 1, int'(levels[0]), 0);
        end
        end_test();
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        reset  = 1'b1;
        cfg_we = 1'b0;
        cfg    = '0;
        void'($urandom(32'h6aa1c81f));
        for (int ch = 0; ch < NUM_CH; ch++) begin
            vol_set[ch] = 0;
            per_set[ch] = 0;
        end
        repeat (8) @(negedge clk);   // Reset for 8 clocks
        check_reset_state();
        check_tone_enables();
        check_sample_enables();
        for (int i = 0; i < NUM_VEC; i++) begin
            idle_gap();
            run_vector(VECTORS[i]);
        end
        check_reconfig_volume();
        check_reconfig_restart();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        int budget;
        budget = run_budget();
        repeat (budget) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clocks", budget);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+test
rtl/sound_pkg.sv
rtl/cen_frac.sv
rtl/cen_div.sv
rtl/tone_bank.sv
rtl/tone_mixer.sv
rtl/sound_timing_top.sv
test/tb_sound_timing.sv

/* run.sh */
#!/bin/bash
# Build and run the sound timing testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module tb_sound_timing -o sim_sound_timing

out="$(./obj_dir/sim_sound_timing)"
echo "$out"

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
else
    exit 1
fi
